// ==== sim.f ====
+incdir+include
hw/pipe_pkg.sv
hw/alu.sv
hw/barrel_shifter.sv
hw/gpr_file.sv
hw/id_stage.sv
hw/ex_stage.sv
hw/exec_pipe_top.sv
test/tb_exec_pipe.sv

// ==== Makefile ====
# Verilator build for the execute pipeline testbench

VERILATOR ?= verilator
TOP       ?= tb_exec_pipe
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert

SOURCES := $(wildcard hw/*.sv) $(wildcard test/*.sv) $(wildcard include/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulator is the result
run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== include/tb_isa.svh ====
`ifndef TB_ISA_SVH
`define TB_ISA_SVH

// Primary opcodes
localparam logic [5:0] opc_special = 6'h00;
localparam logic [5:0] opc_addi    = 6'h08;
localparam logic [5:0] opc_addiu   = 6'h09;
localparam logic [5:0] opc_andi    = 6'h0c;
localparam logic [5:0] opc_ori     = 6'h0d;
localparam logic [5:0] opc_lui     = 6'h0f;

// Funct values under SPECIAL
localparam logic [5:0] fun_sll  = 6'h00;
localparam logic [5:0] fun_srl  = 6'h02;
localparam logic [5:0] fun_sra  = 6'h03;
localparam logic [5:0] fun_sllv = 6'h04;
localparam logic [5:0] fun_add  = 6'h20;
localparam logic [5:0] fun_addu = 6'h21;
localparam logic [5:0] fun_subu = 6'h23;
localparam logic [5:0] fun_and  = 6'h24;
localparam logic [5:0] fun_or   = 6'h25;
localparam logic [5:0] fun_xor  = 6'h26;
localparam logic [5:0] fun_slt  = 6'h2a;

// R-type word, operand order as in assembly
function automatic logic [31:0] r_word(input logic [5:0] funct, input logic [4:0] rd,
                                       input logic [4:0] rs, input logic [4:0] rt,
                                       input logic [4:0] sa);
    return {opc_special, rs, rt, rd, sa, funct};
endfunction

function automatic logic [31:0] i_word(input logic [5:0] opc, input logic [4:0] rt,
                                       input logic [4:0] rs, input logic [15:0] imm);
    return {opc, rs, rt, imm};
endfunction

// rd for SPECIAL, rt otherwise
function automatic logic [4:0] dest_reg(input logic [31:0] word);
    return (word[31:26] == opc_special) ? word[15:11] : word[20:16];
endfunction

// Expected write flag and result of one word
function automatic void ref_exec(
    input  logic [31:0] word,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic        wr,
    output logic [31:0] res
);
    logic [31:0] imm_s;
    logic [31:0] imm_z;
    logic [32:0] wide;
    logic        ok;
    imm_s = {{16{word[15]}}, word[15:0]};
    imm_z = {16'h0000, word[15:0]};
    wide  = '0;
    ok    = 1'b1;
    res   = '0;
    if (word[31:26] == opc_special) begin
        case (word[5:0])
            fun_add: begin
                // One extra sign bit, top two bits differ on overflow
                wide = {a[31], a} + {b[31], b};
                res  = wide[31:0];
                ok   = (wide[32] == wide[31]);
            end
            fun_addu: res = a + b;
            fun_subu: res = a - b;
            fun_and:  res = a & b;
            fun_or:   res = a | b;
            fun_xor:  res = a ^ b;
            fun_slt:  res = {31'd0, ($signed(a) < $signed(b))};
            fun_sll:  res = b << word[10:6];
            fun_srl:  res = b >> word[10:6];
            fun_sra:  res = $signed(b) >>> word[10:6];
            fun_sllv: res = b << a[4:0];
            default:  ok  = 1'b0;
        endcase
    end else begin
        case (word[31:26])
            opc_addi: begin
                wide = {a[31], a} + {imm_s[31], imm_s};
                res  = wide[31:0];
                ok   = (wide[32] == wide[31]);
            end
            opc_addiu: res = a + imm_s;
            // Logic immediates are zero extended
            opc_andi:  res = a & imm_z;
            opc_ori:   res = a | imm_z;
            opc_lui:   res = {word[15:0], 16'h0000};
            default:   ok  = 1'b0;
        endcase
    end
    // $0 is never written
    wr = ok && (dest_reg(word) != 5'd0);
endfunction

`endif

// ==== test/tb_exec_pipe.sv ====
`timescale 1ns/1ps

module tb_exec_pipe;

    `include "tb_isa.svh"

    // Instruction counts per test
    localparam int n_chain = 31;
    localparam int n_dep   = 40;
    localparam int n_shift = 32;
    localparam int n_ovf   = 17;
    localparam int n_misc  = 17;
    localparam int n_total = n_chain + n_dep + n_shift + n_ovf + n_misc;

    logic        clk         = 1'b0;
    logic        rst_n       = 1'b0;
    logic        issue_valid = 1'b0;
    logic [31:0] instr       = '0;
    logic        wb_valid;
    logic [4:0]  wb_rd_addr;
    logic [31:0] wb_data;

    integer      seed;
    string       test_name;
    logic [31:0] regs_ref [0:31];
    int          cyc       = 0;

    // Expected write-backs in issue order
    int          q_due  [$];
    logic        q_wr   [$];
    logic [4:0]  q_rd   [$];
    logic [31:0] q_data [$];
    string       q_name [$];

    // What the DUT should show since the last edge
    logic        exp_v    = 1'b0;
    logic [4:0]  exp_rd   = '0;
    logic [31:0] exp_data = '0;
    string       exp_name;

    exec_pipe_top dut (
        .clk         ( clk ),
        .rst_n       ( rst_n ),
        .issue_valid ( issue_valid ),
        .instr       ( instr ),
        .wb_valid    ( wb_valid ),
        .wb_rd_addr  ( wb_rd_addr ),
        .wb_data     ( wb_data )
    );

    always #10 clk = ~clk;

    ////////////////////
    // Helpers
    ////////////////////
    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    // Model update and expectation, then drive for one cycle
    task automatic issue(input logic [31:0] word);
        logic        wr;
        logic [31:0] res;
        logic [4:0]  rd;
        ref_exec(word, regs_ref[word[25:21]], regs_ref[word[20:16]], wr, res);
        rd = dest_reg(word);
        // EX/WB shows the result two edges on
        q_due.push_back(cyc + 2);
        q_wr.push_back(wr);
        q_rd.push_back(rd);
        q_data.push_back(res);
        q_name.push_back(test_name);
        if (wr) begin
            regs_ref[rd] = res;
        end
        instr       <= word;
        issue_valid <= 1'b1;
        @(posedge clk);
    endtask

    // Full 32-bit constant, ORI depends on LUI
    task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
        issue(i_word(opc_lui, rd, 5'd0, value[31:16]));
        issue(i_word(opc_ori, rd, rd, value[15:0]));
    endtask

    ////////////////////
    // Expected stream
    ////////////////////
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (q_due.size() != 0 && q_due[0] == cyc) begin
            exp_v    <= q_wr.pop_front();
            exp_rd   <= q_rd.pop_front();
            exp_data <= q_data.pop_front();
            exp_name <= q_name.pop_front();
            void'(q_due.pop_front());
        end else begin
            exp_v <= 1'b0;
        end
    end

    // Strobe only when a write is due
    assert property (@(posedge clk) disable iff (!rst_n) wb_valid == exp_v)
        else begin
            $display("ERR %s wb_valid expected %0b actual %0b",
                     exp_name, $sampled(exp_v), $sampled(wb_valid));
            $display("Verification failed");
            $fatal(1, "wb_valid mismatch");
        end

    assert property (@(posedge clk) disable iff (!rst_n) wb_valid |-> (wb_rd_addr == exp_rd))
        else begin
            $display("ERR %s wb_rd_addr expected %0d actual %0d",
                     exp_name, $sampled(exp_rd), $sampled(wb_rd_addr));
            $display("Verification failed");
            $fatal(1, "wb_rd_addr mismatch");
        end

    assert property (@(posedge clk) disable iff (!rst_n) wb_valid |-> (wb_data == exp_data))
        else begin
            $display("ERR %s wb_data expected 0x%08h actual 0x%08h",
                     exp_name, $sampled(exp_data), $sampled(wb_data));
            $display("Verification failed");
            $fatal(1, "wb_data mismatch");
        end

    ////////////////////
    // Stimulus
    ////////////////////
    initial begin
        logic [31:0] w;
        logic [4:0]  rd;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  sa;
        seed = 32'he760_35f2;
        for (int r = 0; r < 32; r++) begin
            regs_ref[r] = '0;
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        // Idle, strobe must stay low
        repeat (3) @(posedge clk);

        // Each register from the one below it
        test_name = "addiu_chain";
        for (int r = 1; r < 32; r++) begin
            w  = rand_word();
            rd = r[4:0];
            issue(i_word(opc_addiu, rd, rd - 5'd1, w[15:0]));
        end

        // Few registers, many back-to-back hazards
        test_name = "dependent_ops";
        for (int n = 0; n < n_dep; n++) begin
            w  = rand_word();
            rs = {2'b00, w[2:0]};
            rt = {2'b00, w[5:3]};
            rd = (w[8:6] == 3'd0) ? 5'd7 : {2'b00, w[8:6]};
            case (w[11:9])
                3'd0:    issue(r_word(fun_addu, rd, rs, rt, 5'd0));
                3'd1:    issue(r_word(fun_subu, rd, rs, rt, 5'd0));
                3'd2:    issue(r_word(fun_and, rd, rs, rt, 5'd0));
                3'd3:    issue(r_word(fun_or, rd, rs, rt, 5'd0));
                3'd4:    issue(r_word(fun_xor, rd, rs, rt, 5'd0));
                3'd5:    issue(i_word(opc_addiu, rd, rs, w[31:16]));
                3'd6:    issue(i_word(opc_andi, rd, rs, w[31:16]));
                default: issue(i_word(opc_ori, rd, rs, w[31:16]));
            endcase
        end

        test_name = "shifts";
        for (int n = 0; n < n_shift; n++) begin
            w  = rand_word();
            rt = w[4:0];
            rs = w[9:5];
            rd = w[14:10];
            sa = w[19:15];
            case (w[21:20])
                2'd0:    issue(r_word(fun_sll, rd, 5'd0, rt, sa));
                2'd1:    issue(r_word(fun_srl, rd, 5'd0, rt, sa));
                2'd2:    issue(r_word(fun_sra, rd, 5'd0, rt, sa));
                default: issue(r_word(fun_sllv, rd, rs, rt, 5'd0));
            endcase
        end

        // Overflowing ADD/ADDI leave the target as it was
        test_name = "overflow";
        load_reg(5'd1, 32'h7fff_fff0);
        load_reg(5'd2, 32'h0000_0100);
        issue(r_word(fun_add, 5'd3, 5'd1, 5'd2, 5'd0));
        issue(r_word(fun_addu, 5'd4, 5'd1, 5'd2, 5'd0));
        issue(i_word(opc_addi, 5'd5, 5'd1, 16'h7fff));
        issue(r_word(fun_or, 5'd6, 5'd3, 5'd0, 5'd0));
        issue(r_word(fun_or, 5'd10, 5'd5, 5'd0, 5'd0));
        load_reg(5'd7, 32'h8000_0005);
        issue(r_word(fun_add, 5'd8, 5'd7, 5'd7, 5'd0));
        issue(i_word(opc_addi, 5'd9, 5'd7, 16'hfff0));
        issue(r_word(fun_addu, 5'd11, 5'd7, 5'd7, 5'd0));
        issue(r_word(fun_or, 5'd12, 5'd8, 5'd0, 5'd0));
        issue(r_word(fun_or, 5'd13, 5'd9, 5'd0, 5'd0));
        // Mixed signs never overflow
        issue(r_word(fun_add, 5'd14, 5'd1, 5'd7, 5'd0));

        test_name = "compare_and_ext";
        load_reg(5'd15, 32'hffff_fff0);
        load_reg(5'd16, 32'h0000_0010);
        issue(r_word(fun_slt, 5'd17, 5'd15, 5'd16, 5'd0));
        issue(r_word(fun_slt, 5'd18, 5'd16, 5'd15, 5'd0));
        issue(r_word(fun_slt, 5'd19, 5'd1, 5'd7, 5'd0));
        issue(r_word(fun_slt, 5'd20, 5'd7, 5'd1, 5'd0));
        issue(i_word(opc_lui, 5'd21, 5'd0, 16'h8001));
        issue(i_word(opc_andi, 5'd22, 5'd15, 16'h8f0f));
        issue(i_word(opc_ori, 5'd23, 5'd16, 16'h8000));
        issue(i_word(opc_addiu, 5'd24, 5'd16, 16'hfffc));
        // No strobe for $0 or for unknown words
        issue(i_word(opc_addiu, 5'd0, 5'd1, 16'h0005));
        issue(r_word(fun_addu, 5'd0, 5'd1, 5'd2, 5'd0));
        issue(32'hfc00_0000);
        issue(r_word(6'h3f, 5'd26, 5'd1, 5'd2, 5'd0));
        issue(r_word(fun_or, 5'd25, 5'd0, 5'd15, 5'd0));

        issue_valid <= 1'b0;
        // Drain, then one more edge for the last check
        while (q_due.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        $display("Verification passed");
        $finish;
    end

    ////////////////////
    // Watchdog
    ////////////////////
    initial begin
        #((n_total + 50) * 20);
        $display("Timeout, the run did not finish within %0d cycles", n_total + 50);
        $display("Verification failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== hw/exec_pipe_top.sv ====
`timescale 1ns/1ps

module exec_pipe_top (
    input  logic                           clk,
    input  logic                           rst_n,
    // Issue port
    input  logic                           issue_valid,
    input  logic [pipe_pkg::data_width-1:0] instr,
    // Write-back strobe
    output logic                           wb_valid,
    output logic [pipe_pkg::reg_addr_width-1:0] wb_rd_addr,
    output logic [pipe_pkg::data_width-1:0] wb_data
);

    ////////////////////
    // ID side
    ////////////////////
    logic [pipe_pkg::reg_addr_width-1:0] rs_addr;
    logic [pipe_pkg::reg_addr_width-1:0] rt_addr;
    logic [pipe_pkg::data_width-1:0]     rs_data;
    logic [pipe_pkg::data_width-1:0]     rt_data;

    // ID/EX contents
    logic [pipe_pkg::reg_addr_width-1:0] ex_rs_addr;
    logic [pipe_pkg::reg_addr_width-1:0] ex_rt_addr;
    logic [pipe_pkg::reg_addr_width-1:0] ex_rd_addr;
    logic                                ex_reg_w;
    logic                                ex_of_check;
    logic [2:0]                          ex_alu_op;
    logic [1:0]                          ex_shift_op;
    logic                                ex_res_sel;
    logic                                ex_b_imm;
    logic                                ex_shamt_reg;
    logic [4:0]                          ex_shamt;
    logic [pipe_pkg::data_width-1:0]     ex_imm_ext;
    logic [pipe_pkg::data_width-1:0]     ex_rs_data;
    logic [pipe_pkg::data_width-1:0]     ex_rt_data;

    // Decode and ID/EX
    id_stage u_id_stage (
        .clk          ( clk ),
        .rst_n        ( rst_n ),
        .issue_valid  ( issue_valid ),
        .instr        ( instr ),
        .rs_data      ( rs_data ),
        .rt_data      ( rt_data ),
        .rs_addr      ( rs_addr ),
        .rt_addr      ( rt_addr ),
        .ex_rs_addr   ( ex_rs_addr ),
        .ex_rt_addr   ( ex_rt_addr ),
        .ex_rd_addr   ( ex_rd_addr ),
        .ex_reg_w     ( ex_reg_w ),
        .ex_of_check  ( ex_of_check ),
        .ex_alu_op    ( ex_alu_op ),
        .ex_shift_op  ( ex_shift_op ),
        .ex_res_sel   ( ex_res_sel ),
        .ex_b_imm     ( ex_b_imm ),
        .ex_shamt_reg ( ex_shamt_reg ),
        .ex_shamt     ( ex_shamt ),
        .ex_imm_ext   ( ex_imm_ext ),
        .ex_rs_data   ( ex_rs_data ),
        .ex_rt_data   ( ex_rt_data )
    );

    // GPR, written straight from EX/WB
    gpr_file u_gpr_file (
        .clk     ( clk ),
        .rst_n   ( rst_n ),
        .we      ( wb_valid ),
        .wr_addr ( wb_rd_addr ),
        .wr_data ( wb_data ),
        .rs_addr ( rs_addr ),
        .rt_addr ( rt_addr ),
        .rs_data ( rs_data ),
        .rt_data ( rt_data )
    );

    ////////////////////
    // EX and EX/WB
    ////////////////////
    ex_stage u_ex_stage (
        .clk          ( clk ),
        .rst_n        ( rst_n ),
        .ex_rs_addr   ( ex_rs_addr ),
        .ex_rt_addr   ( ex_rt_addr ),
        .ex_rd_addr   ( ex_rd_addr ),
        .ex_reg_w     ( ex_reg_w ),
        .ex_of_check  ( ex_of_check ),
        .ex_alu_op    ( ex_alu_op ),
        .ex_shift_op  ( ex_shift_op ),
        .ex_res_sel   ( ex_res_sel ),
        .ex_b_imm     ( ex_b_imm ),
        .ex_shamt_reg ( ex_shamt_reg ),
        .ex_shamt     ( ex_shamt ),
        .ex_imm_ext   ( ex_imm_ext ),
        .ex_rs_data   ( ex_rs_data ),
        .ex_rt_data   ( ex_rt_data ),
        .wb_valid     ( wb_valid ),
        .wb_rd_addr   ( wb_rd_addr ),
        .wb_data      ( wb_data )
    );

endmodule

// ==== hw/ex_stage.sv ====
`timescale 1ns/1ps

module ex_stage (
    input  logic                                clk,
    input  logic                                rst_n,
    // From ID/EX
    input  logic [pipe_pkg::reg_addr_width-1:0] ex_rs_addr,
    input  logic [pipe_pkg::reg_addr_width-1:0] ex_rt_addr,
    input  logic [pipe_pkg::reg_addr_width-1:0] ex_rd_addr,
    input  logic                                ex_reg_w,
    input  logic                                ex_of_check,
    input  logic [2:0]                          ex_alu_op,
    input  logic [1:0]                          ex_shift_op,
    input  logic                                ex_res_sel,
    input  logic                                ex_b_imm,
    input  logic                                ex_shamt_reg,
    input  logic [4:0]                          ex_shamt,
    input  logic [pipe_pkg::data_width-1:0]     ex_imm_ext,
    input  logic [pipe_pkg::data_width-1:0]     ex_rs_data,
    input  logic [pipe_pkg::data_width-1:0]     ex_rt_data,
    // EX/WB register
    output logic                                wb_valid,
    output logic [pipe_pkg::reg_addr_width-1:0] wb_rd_addr,
    output logic [pipe_pkg::data_width-1:0]     wb_data
);

    logic [pipe_pkg::data_width-1:0] op_a;
    logic [pipe_pkg::data_width-1:0] fwd_b;
    logic [pipe_pkg::data_width-1:0] op_b;
    logic [4:0]                      shamt_sel;
    logic [pipe_pkg::data_width-1:0] alu_out;
    logic [pipe_pkg::data_width-1:0] shift_out;
    logic                            alu_of;
    logic [pipe_pkg::data_width-1:0] ex_result;
    logic                            ex_write;

    ////////////////////
    // Forwarding
    ////////////////////
    // Only from EX/WB, older results come through the GPR bypass
    // wb_valid is never set for $0, so no zero check here
    assign op_a  = (wb_valid && (wb_rd_addr == ex_rs_addr)) ? wb_data : ex_rs_data;
    assign fwd_b = (wb_valid && (wb_rd_addr == ex_rt_addr)) ? wb_data : ex_rt_data;

    // Immediate forms
    assign op_b = ex_b_imm ? ex_imm_ext : fwd_b;

    // SLLV takes the amount from rs
    assign shamt_sel = ex_shamt_reg ? op_a[4:0] : ex_shamt;

    alu u_alu (
        .a        ( op_a ),
        .b        ( op_b ),
        .alu_op   ( ex_alu_op ),
        .result   ( alu_out ),
        .overflow ( alu_of )
    );

    // Shifts always act on rt
    barrel_shifter u_shifter (
        .data_in  ( fwd_b ),
        .shamt    ( shamt_sel ),
        .shift_op ( ex_shift_op ),
        .data_out ( shift_out )
    );

    assign ex_result = (ex_res_sel == pipe_pkg::res_shift) ? shift_out : alu_out;

    // ADD/ADDI drop the write on signed overflow
    assign ex_write = ex_reg_w && !(ex_of_check && alu_of);

    ////////////////////
    // EX/WB register
    ////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= ex_write;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd_addr <= ex_rd_addr;
        wb_data    <= ex_result;
    end

endmodule

// ==== hw/id_stage.sv ====
`timescale 1ns/1ps

module id_stage (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                issue_valid,
    input  pipe_pkg::instr_u                    instr,
    input  logic [pipe_pkg::data_width-1:0]     rs_data,
    input  logic [pipe_pkg::data_width-1:0]     rt_data,
    output logic [pipe_pkg::reg_addr_width-1:0] rs_addr,
    output logic [pipe_pkg::reg_addr_width-1:0] rt_addr,
    // ID/EX register
    output logic [pipe_pkg::reg_addr_width-1:0] ex_rs_addr,
    output logic [pipe_pkg::reg_addr_width-1:0] ex_rt_addr,
    output logic [pipe_pkg::reg_addr_width-1:0] ex_rd_addr,
    output logic                                ex_reg_w,
    output logic                                ex_of_check,
    output logic [2:0]                          ex_alu_op,
    output logic [1:0]                          ex_shift_op,
    output logic                                ex_res_sel,
    output logic                                ex_b_imm,
    output logic                                ex_shamt_reg,
    output logic [4:0]                          ex_shamt,
    output logic [pipe_pkg::data_width-1:0]     ex_imm_ext,
    output logic [pipe_pkg::data_width-1:0]     ex_rs_data,
    output logic [pipe_pkg::data_width-1:0]     ex_rt_data
);

    logic                                dec_ok;
    logic                                dec_r_type;
    logic                                dec_of_check;
    logic [2:0]                          dec_alu_op;
    logic [1:0]                          dec_shift_op;
    logic                                dec_res_sel;
    logic                                dec_b_imm;
    logic                                dec_shamt_reg;
    logic                                dec_sign_ext;
    logic [pipe_pkg::reg_addr_width-1:0] dec_rd_addr;
    logic [pipe_pkg::data_width-1:0]     dec_imm_ext;
    logic                                dec_reg_w;

    // Source indices sit at the same place in both formats
    assign rs_addr = instr.r.rs;
    assign rt_addr = instr.i.rt;

    ////////////////////
    // Decode
    ////////////////////
    always_comb begin
        // I-type add by default
        dec_ok        = 1'b1;
        dec_r_type    = 1'b0;
        dec_of_check  = 1'b0;
        dec_alu_op    = pipe_pkg::alu_add;
        dec_shift_op  = pipe_pkg::sh_sll;
        dec_res_sel   = pipe_pkg::res_alu;
        dec_b_imm     = 1'b1;
        dec_shamt_reg = 1'b0;
        dec_sign_ext  = 1'b0;
        case (instr.r.opcode)
            pipe_pkg::op_special: begin
                dec_r_type = 1'b1;
                dec_b_imm  = 1'b0;
                case (instr.r.funct)
                    pipe_pkg::fn_add:  dec_of_check = 1'b1;
                    pipe_pkg::fn_addu: dec_alu_op   = pipe_pkg::alu_add;
                    pipe_pkg::fn_subu: dec_alu_op   = pipe_pkg::alu_sub;
                    pipe_pkg::fn_and:  dec_alu_op   = pipe_pkg::alu_and;
                    pipe_pkg::fn_or:   dec_alu_op   = pipe_pkg::alu_or;
                    pipe_pkg::fn_xor:  dec_alu_op   = pipe_pkg::alu_xor;
                    pipe_pkg::fn_slt:  dec_alu_op   = pipe_pkg::alu_slt;
                    pipe_pkg::fn_sll:  dec_res_sel  = pipe_pkg::res_shift;
                    pipe_pkg::fn_srl: begin
                        dec_res_sel  = pipe_pkg::res_shift;
                        dec_shift_op = pipe_pkg::sh_srl;
                    end
                    pipe_pkg::fn_sra: begin
                        dec_res_sel  = pipe_pkg::res_shift;
                        dec_shift_op = pipe_pkg::sh_sra;
                    end
                    // Amount from rs
                    pipe_pkg::fn_sllv: begin
                        dec_res_sel   = pipe_pkg::res_shift;
                        dec_shamt_reg = 1'b1;
                    end
                    default: dec_ok = 1'b0;
                endcase
            end
            pipe_pkg::op_addi: begin
                dec_sign_ext = 1'b1;
                dec_of_check = 1'b1;
            end
            pipe_pkg::op_addiu: dec_sign_ext = 1'b1;
            pipe_pkg::op_andi:  dec_alu_op   = pipe_pkg::alu_and;
            pipe_pkg::op_ori:   dec_alu_op   = pipe_pkg::alu_or;
            // Raw immediate, ALU moves it up
            pipe_pkg::op_lui:   dec_alu_op   = pipe_pkg::alu_lui;
            default:            dec_ok       = 1'b0;
        endcase
    end

    // rd for R-type, rt for I-type
    assign dec_rd_addr = dec_r_type ? instr.r.rd : instr.i.rt;
    assign dec_imm_ext = dec_sign_ext ? {{16{instr.i.imm[15]}}, instr.i.imm}
                                      : {16'h0000, instr.i.imm};
    // No write for unknown words or $0
    assign dec_reg_w = dec_ok && (dec_rd_addr != '0);

    ////////////////////
    // ID/EX register
    ////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_reg_w <= 1'b0;
        end else begin
            ex_reg_w <= issue_valid && dec_reg_w;
        end
    end

    // Payload held while idle
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            ex_rs_addr   <= instr.r.rs;
            ex_rt_addr   <= instr.i.rt;
            ex_rd_addr   <= dec_rd_addr;
            ex_of_check  <= dec_of_check;
            ex_alu_op    <= dec_alu_op;
            ex_shift_op  <= dec_shift_op;
            ex_res_sel   <= dec_res_sel;
            ex_b_imm     <= dec_b_imm;
            ex_shamt_reg <= dec_shamt_reg;
            ex_shamt     <= instr.r.shamt;
            ex_imm_ext   <= dec_imm_ext;
            ex_rs_data   <= rs_data;
            ex_rt_data   <= rt_data;
        end
    end

endmodule

// ==== hw/gpr_file.sv ====
`timescale 1ns/1ps

module gpr_file (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                we,
    input  logic [pipe_pkg::reg_addr_width-1:0] wr_addr,
    input  logic [pipe_pkg::data_width-1:0]     wr_data,
    input  logic [pipe_pkg::reg_addr_width-1:0] rs_addr,
    input  logic [pipe_pkg::reg_addr_width-1:0] rt_addr,
    output logic [pipe_pkg::data_width-1:0]     rs_data,
    output logic [pipe_pkg::data_width-1:0]     rt_data
);

    // $1 to $31, $0 has no storage
    logic [pipe_pkg::data_width-1:0] regs [1:pipe_pkg::num_regs-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < pipe_pkg::num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    ////////////////////
    // Read ports
    ////////////////////
    // Write-first, covers the two-ahead hazard
    function automatic logic [pipe_pkg::data_width-1:0] read_port(
        input logic [pipe_pkg::reg_addr_width-1:0] addr
    );
        if (addr == '0) begin
            return '0;
        end else if (we && (wr_addr == addr)) begin
            return wr_data;
        end
        return regs[addr];
    endfunction

    // Also follows the write port and the storage
    always_comb begin
        rs_data = read_port(rs_addr);
        rt_data = read_port(rt_addr);
    end

endmodule

// ==== hw/barrel_shifter.sv ====
`timescale 1ns/1ps

module barrel_shifter (
    input  logic [pipe_pkg::data_width-1:0] data_in,
    input  logic [4:0]                      shamt,
    input  logic [1:0]                      shift_op,
    output logic [pipe_pkg::data_width-1:0] data_out
);

    logic                            left;
    logic                            fill;
    logic [pipe_pkg::data_width-1:0] stage [0:5];

    assign left = (shift_op == pipe_pkg::sh_sll);
    // Sign fill only for SRA
    assign fill = (shift_op == pipe_pkg::sh_sra) && data_in[31];

    // Left shift runs as a right shift on the reversed word
    assign stage[0] = left ? {<<{data_in}} : data_in;

    ////////////////////
    // Log stages
    ////////////////////
    // Stage k moves by 2**k places
    for (genvar k = 0; k < 5; k++) begin : g_stage
        assign stage[k+1] = shamt[k] ? {{(1 << k){fill}}, stage[k][31:(1 << k)]}
                                     : stage[k];
    end

    // Undo the reversal
    assign data_out = left ? {<<{stage[5]}} : stage[5];

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  logic [pipe_pkg::data_width-1:0] a,
    input  logic [pipe_pkg::data_width-1:0] b,
    input  logic [2:0]                      alu_op,
    output logic [pipe_pkg::data_width-1:0] result,
    output logic                            overflow
);

    logic [pipe_pkg::data_width-1:0] sum;
    logic [pipe_pkg::data_width-1:0] diff;
    logic                            add_of;
    logic                            sub_of;
    logic                            less;

    assign sum  = a + b;
    assign diff = a - b;

    // Signed overflow from the sign bits
    assign add_of = (a[31] == b[31]) && (sum[31] != a[31]);
    assign sub_of = (a[31] != b[31]) && (diff[31] != a[31]);

    // Signed compare
    assign less = $signed(a) < $signed(b);

    always_comb begin
        overflow = 1'b0;
        case (alu_op)
            pipe_pkg::alu_add: begin
                result   = sum;
                overflow = add_of;
            end
            pipe_pkg::alu_sub: begin
                result   = diff;
                overflow = sub_of;
            end
            pipe_pkg::alu_and: result = a & b;
            pipe_pkg::alu_or:  result = a | b;
            pipe_pkg::alu_xor: result = a ^ b;
            pipe_pkg::alu_slt: result = {31'd0, less};
            // Immediate into the upper half
            pipe_pkg::alu_lui: result = {b[15:0], 16'h0000};
            default:           result = sum;
        endcase
    end

endmodule

// ==== hw/pipe_pkg.sv ====
package pipe_pkg;

    ////////////////////
    // Widths
    ////////////////////
    localparam int data_width     = 32;
    localparam int reg_addr_width = 5;
    localparam int num_regs       = 32;

    // Instruction word, seen as R-type or I-type
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i;
    } instr_u;

    ////////////////////
    // Opcodes
    ////////////////////
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_addi    = 6'h08;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_lui     = 6'h0f;

    // Funct field of SPECIAL
    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_srl  = 6'h02;
    localparam logic [5:0] fn_sra  = 6'h03;
    localparam logic [5:0] fn_sllv = 6'h04;
    localparam logic [5:0] fn_add  = 6'h20;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_slt  = 6'h2a;

    ////////////////////
    // Execute controls
    ////////////////////
    localparam logic [2:0] alu_add = 3'd0;
    localparam logic [2:0] alu_sub = 3'd1;
    localparam logic [2:0] alu_and = 3'd2;
    localparam logic [2:0] alu_or  = 3'd3;
    localparam logic [2:0] alu_xor = 3'd4;
    localparam logic [2:0] alu_slt = 3'd5;
    localparam logic [2:0] alu_lui = 3'd6;

    localparam logic [1:0] sh_sll = 2'd0;
    localparam logic [1:0] sh_srl = 2'd1;
    localparam logic [1:0] sh_sra = 2'd2;

    // Result source in EX
    localparam logic res_alu   = 1'b0;
    localparam logic res_shift = 1'b1;

endpackage
